//--- src/nco_pkg.sv
/*
 * nco shared definitions: widths, CSR map, reset values and the
 * control bundles passed between the bus and oscillator clock domains
 */
`default_nettype none

package nco_pkg;

   // period is unsigned fixed point, integer part above the fraction
   localparam int PERIOD_W = 16;
   localparam int FRAC_W   = 8;
   localparam int INT_W    = PERIOD_W - FRAC_W;

   // register interface
   localparam int CSR_ADDR_W = 2;
   localparam int CSR_DATA_W = 16;

   localparam logic [CSR_ADDR_W-1:0] ADDR_SOFT_RESET = 2'd0;
   localparam logic [CSR_ADDR_W-1:0] ADDR_ENABLE     = 2'd1;
   localparam logic [CSR_ADDR_W-1:0] ADDR_PERIOD     = 2'd2;

   // 4.0 in_clk_i cycles
   localparam logic [PERIOD_W-1:0] PERIOD_RST = {INT_W'(4), FRAC_W'(0)};

   // bus clock domain, csrs to sync
   typedef struct packed {
      logic                soft_reset;
      logic                enable;
      logic                period_wen;
      logic [PERIOD_W-1:0] period_wdata;
   } csr_ctrl_t;

   // oscillator clock domain, sync to accumulator
   typedef struct packed {
      logic                soft_reset;
      logic                enable;
      logic                period_wen;
      logic [PERIOD_W-1:0] period;
   } nco_ctrl_t;

endpackage

`default_nettype wire

//--- src/nco_csrs.sv
/*
 * nco control registers: soft reset, enable and period, with
 * registered readback and a one-cycle strobe on each period write
 */
`default_nettype none

module nco_csrs (
   input  wire                                clk_i,
   input  wire                                rst_i,
   input  wire                                csr_valid_i,
   input  wire                                csr_we_i,
   input  wire        [nco_pkg::CSR_ADDR_W-1:0] csr_addr_i,
   input  wire        [nco_pkg::CSR_DATA_W-1:0] csr_wdata_i,
   output logic       [nco_pkg::CSR_DATA_W-1:0] csr_rdata_o,
   output nco_pkg::csr_ctrl_t                   ctrl_o
);

   logic wr;
   logic rd;

   assign wr = csr_valid_i & csr_we_i;
   assign rd = csr_valid_i & ~csr_we_i;

   // soft reset, bit 0
   logic soft_reset_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         soft_reset_q <= 1'b0;
      end else if (wr && csr_addr_i == nco_pkg::ADDR_SOFT_RESET) begin
         soft_reset_q <= csr_wdata_i[0];
      end
   end

   // enable, bit 0
   logic enable_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q <= 1'b0;
      end else if (wr && csr_addr_i == nco_pkg::ADDR_ENABLE) begin
         enable_q <= csr_wdata_i[0];
      end
   end

   // period value and its write strobe, both valid the cycle after the access
   logic [nco_pkg::PERIOD_W-1:0] period_q;
   logic                         period_wen_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         period_q     <= nco_pkg::PERIOD_RST;
         period_wen_q <= 1'b0;
      end else begin
         period_wen_q <= wr && csr_addr_i == nco_pkg::ADDR_PERIOD;
         if (wr && csr_addr_i == nco_pkg::ADDR_PERIOD) begin
            period_q <= csr_wdata_i[nco_pkg::PERIOD_W-1:0];
         end
      end
   end

   // readback mux, captured only on a read so data holds in between
   logic [nco_pkg::CSR_DATA_W-1:0] rdata_nxt;

   always_comb begin
      case (csr_addr_i)
         nco_pkg::ADDR_SOFT_RESET: rdata_nxt = {{(nco_pkg::CSR_DATA_W-1){1'b0}}, soft_reset_q};
         nco_pkg::ADDR_ENABLE:     rdata_nxt = {{(nco_pkg::CSR_DATA_W-1){1'b0}}, enable_q};
         nco_pkg::ADDR_PERIOD:     rdata_nxt = period_q;
         default:                  rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         csr_rdata_o <= '0;
      end else if (rd) begin
         csr_rdata_o <= rdata_nxt;
      end
   end

   always_comb begin
      ctrl_o.soft_reset   = soft_reset_q;
      ctrl_o.enable       = enable_q;
      ctrl_o.period_wen   = period_wen_q;
      ctrl_o.period_wdata = period_q;
   end

endmodule

`default_nettype wire

//--- src/nco_period_fifo.sv
/*
 * two-entry asynchronous FIFO for period values, Gray-coded pointers
 * synchronized over two flops into the opposite clock domain
 */
`default_nettype none

module nco_period_fifo (
   // write side, bus clock
   input  wire                              w_clk_i,
   input  wire                              w_rst_i,
   input  wire                              w_en_i,
   input  wire  [nco_pkg::PERIOD_W-1:0]     w_data_i,
   output logic                             w_full_o,
   // read side, oscillator clock
   input  wire                              r_clk_i,
   input  wire                              r_rst_i,
   input  wire                              r_en_i,
   output logic [nco_pkg::PERIOD_W-1:0]     r_data_o,
   output logic                             r_empty_o
);

   // one address bit plus a wrap bit per pointer
   logic [nco_pkg::PERIOD_W-1:0] mem [2];

   logic [1:0] w_bin;
   logic [1:0] w_gray;
   logic [1:0] r_gray_meta;
   logic [1:0] r_gray_sync;

   logic [1:0] r_bin;
   logic [1:0] r_gray;
   logic [1:0] w_gray_meta;
   logic [1:0] w_gray_sync;

   logic       w_push;
   logic       r_pop;
   logic [1:0] w_bin_nxt;
   logic [1:0] r_bin_nxt;

   // full when the write pointer is one lap ahead, both Gray bits inverted
   assign w_full_o  = (w_gray == ~r_gray_sync);
   assign r_empty_o = (r_gray == w_gray_sync);

   assign w_push    = w_en_i & ~w_full_o;
   assign r_pop     = r_en_i & ~r_empty_o;
   assign w_bin_nxt = w_bin + 2'd1;
   assign r_bin_nxt = r_bin + 2'd1;

   // write pointer and read pointer synchronizer
   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_bin       <= '0;
         w_gray      <= '0;
         r_gray_meta <= '0;
         r_gray_sync <= '0;
      end else begin
         r_gray_meta <= r_gray;
         r_gray_sync <= r_gray_meta;
         if (w_push) begin
            w_bin  <= w_bin_nxt;
            w_gray <= w_bin_nxt ^ (w_bin_nxt >> 1);
         end
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem[w_bin[0]] <= w_data_i;
      end
   end

   // read pointer and write pointer synchronizer
   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_bin       <= '0;
         r_gray      <= '0;
         w_gray_meta <= '0;
         w_gray_sync <= '0;
      end else begin
         w_gray_meta <= w_gray;
         w_gray_sync <= w_gray_meta;
         if (r_pop) begin
            r_bin  <= r_bin_nxt;
            r_gray <= r_bin_nxt ^ (r_bin_nxt >> 1);
         end
      end
   end

   // read data registered, holds until the next pop
   always_ff @(posedge r_clk_i) begin
      if (r_pop) begin
         r_data_o <= mem[r_bin[0]];
      end
   end

endmodule

`default_nettype wire

//--- src/nco_sync.sv
/*
 * nco clock domain crossing: reset and control level synchronizers,
 * period FIFO and the period arrival strobe in the in_clk_i domain
 */
`default_nettype none

module nco_sync (
   input  wire                clk_i,
   input  wire                rst_i,
   input  wire                in_clk_i,
   input  wire nco_pkg::csr_ctrl_t csr_ctrl_i,
   output logic               in_rst_o,
   output nco_pkg::nco_ctrl_t nco_ctrl_o
);

   // reset into the oscillator domain
   logic rst_meta;

   always_ff @(posedge in_clk_i) begin
      rst_meta <= rst_i;
      in_rst_o <= rst_meta;
   end

   // soft reset and enable travel together, bit 1 soft reset, bit 0 enable
   logic [1:0] lvl_meta;
   logic [1:0] lvl_q;

   always_ff @(posedge in_clk_i) begin
      if (in_rst_o) begin
         lvl_meta <= '0;
         lvl_q    <= '0;
      end else begin
         lvl_meta <= {csr_ctrl_i.soft_reset, csr_ctrl_i.enable};
         lvl_q    <= lvl_meta;
      end
   end

   // period writes made while soft reset is held are dropped
   logic                         fifo_w_en;
   logic                         fifo_w_full;
   logic                         fifo_r_en;
   logic                         fifo_empty;
   logic [nco_pkg::PERIOD_W-1:0] fifo_r_data;

   assign fifo_w_en = csr_ctrl_i.period_wen & ~csr_ctrl_i.soft_reset;
   assign fifo_r_en = ~fifo_empty;

   nco_period_fifo u_fifo (
      .w_clk_i  (clk_i),
      .w_rst_i  (rst_i),
      .w_en_i   (fifo_w_en),
      .w_data_i (csr_ctrl_i.period_wdata),
      .w_full_o (fifo_w_full),
      .r_clk_i  (in_clk_i),
      .r_rst_i  (in_rst_o),
      .r_en_i   (fifo_r_en),
      .r_data_o (fifo_r_data),
      .r_empty_o(fifo_empty)
   );

   // new period is on the FIFO output one cycle after the pop
   logic period_wen_q;

   always_ff @(posedge in_clk_i) begin
      if (in_rst_o) begin
         period_wen_q <= 1'b0;
      end else begin
         period_wen_q <= fifo_r_en;
      end
   end

   always_comb begin
      nco_ctrl_o.soft_reset = lvl_q[1];
      nco_ctrl_o.enable     = lvl_q[0];
      nco_ctrl_o.period_wen = period_wen_q;
      nco_ctrl_o.period     = fifo_r_data;
   end

endmodule

`default_nettype wire

//--- src/nco_accum.sv
/*
 * nco fractional period accumulator: counts in_clk_i cycles per output
 * period and stretches a period by one cycle on each fraction carry
 */
`default_nettype none

module nco_accum (
   input  wire                     in_clk_i,
   input  wire                     in_rst_i,
   input  wire nco_pkg::nco_ctrl_t ctrl_i,
   output logic                    clk_o
);

   localparam int IW = nco_pkg::INT_W;
   localparam int FW = nco_pkg::FRAC_W;

   logic [nco_pkg::PERIOD_W-1:0] period_q;
   logic [IW:0]                  cnt_q;
   logic [FW-1:0]                acc_q;

   logic                         run;
   logic [nco_pkg::PERIOD_W-1:0] period_sel;
   logic [IW-1:0]                half;
   logic [FW:0]                  sum;
   logic [IW:0]                  len;
   logic                         wrap;
   logic [IW:0]                  cnt_nxt;

   assign run = ctrl_i.enable & ~ctrl_i.soft_reset;

   // a new period takes effect on the strobe edge itself
   assign period_sel = ctrl_i.period_wen ? ctrl_i.period : period_q;
   assign half       = period_sel[nco_pkg::PERIOD_W-1:FW] >> 1;

   // carry out of the fraction adds one cycle to this period
   assign sum  = {1'b0, acc_q} + {1'b0, period_q[FW-1:0]};
   assign len  = {1'b0, period_q[nco_pkg::PERIOD_W-1:FW]} + (IW+1)'(sum[FW]);
   assign wrap = (cnt_q + 1'b1) >= len;

   always_comb begin
      if (!run || ctrl_i.period_wen || wrap) begin
         cnt_nxt = '0;
      end else begin
         cnt_nxt = cnt_q + 1'b1;
      end
   end

   always_ff @(posedge in_clk_i) begin
      if (in_rst_i) begin
         period_q <= nco_pkg::PERIOD_RST;
         cnt_q    <= '0;
         acc_q    <= '0;
         clk_o    <= 1'b0;
      end else begin
         if (ctrl_i.period_wen) begin
            period_q <= ctrl_i.period;
         end
         cnt_q <= cnt_nxt;
         // fraction restarts with a new period or when idle
         if (!run || ctrl_i.period_wen) begin
            acc_q <= '0;
         end else if (wrap) begin
            acc_q <= sum[FW-1:0];
         end
         // high for the first half of the integer part
         clk_o <= run && (cnt_nxt < {1'b0, half});
      end
   end

endmodule

`default_nettype wire

//--- src/nco_top.sv
/*
 * nco top level: CSR block, clock domain crossing and accumulator
 */
`default_nettype none

module nco_top (
   input  wire                              clk_i,
   input  wire                              rst_i,
   input  wire                              in_clk_i,
   input  wire                              csr_valid_i,
   input  wire                              csr_we_i,
   input  wire  [nco_pkg::CSR_ADDR_W-1:0]   csr_addr_i,
   input  wire  [nco_pkg::CSR_DATA_W-1:0]   csr_wdata_i,
   output logic [nco_pkg::CSR_DATA_W-1:0]   csr_rdata_o,
   output logic                             clk_o
);

   nco_pkg::csr_ctrl_t csr_ctrl;
   nco_pkg::nco_ctrl_t nco_ctrl;
   logic               in_rst;

   nco_csrs u_csrs (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .csr_valid_i(csr_valid_i),
      .csr_we_i   (csr_we_i),
      .csr_addr_i (csr_addr_i),
      .csr_wdata_i(csr_wdata_i),
      .csr_rdata_o(csr_rdata_o),
      .ctrl_o     (csr_ctrl)
   );

   // bus domain to oscillator domain
   nco_sync u_sync (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .in_clk_i  (in_clk_i),
      .csr_ctrl_i(csr_ctrl),
      .in_rst_o  (in_rst),
      .nco_ctrl_o(nco_ctrl)
   );

   nco_accum u_accum (
      .in_clk_i(in_clk_i),
      .in_rst_i(in_rst),
      .ctrl_i  (nco_ctrl),
      .clk_o   (clk_o)
   );

endmodule

`default_nettype wire

//--- sim/nco_properties.sv
/*
 * nco checks bound into the synchronizer and the accumulator
 */
`default_nettype none

module nco_properties #(
   // selects the synchronizer checks over the accumulator check
   parameter bit SYNC_SIDE = 1'b1
) (
   input wire                     clk_i,
   input wire                     rst_i,
   input wire                     w_en_i,
   input wire                     w_full_i,
   input wire                     in_clk_i,
   input wire                     in_rst_i,
   input wire nco_pkg::nco_ctrl_t ctrl_i,
   input wire                     clk_o_i
);

   if (SYNC_SIDE) begin : g_sync
      // one period in flight at a time, so the strobe never stretches
      wen_one_cycle: assert property (@(posedge in_clk_i) disable iff (in_rst_i)
         ctrl_i.period_wen |=> !ctrl_i.period_wen)
         else $error("period_wen high for more than one in_clk_i cycle");

      no_write_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
         w_en_i |-> !w_full_i)
         else $error("period FIFO written while full");
   end else begin : g_accum
      low_when_disabled: assert property (@(posedge in_clk_i) disable iff (in_rst_i)
         !ctrl_i.enable |=> !clk_o_i)
         else $error("clk_o high while enable is low");
   end

endmodule

bind nco_sync nco_properties #(.SYNC_SIDE(1'b1)) u_sync_props (
   .clk_i   (clk_i),
   .rst_i   (rst_i),
   .w_en_i  (fifo_w_en),
   .w_full_i(fifo_w_full),
   .in_clk_i(in_clk_i),
   .in_rst_i(in_rst_o),
   .ctrl_i  (nco_ctrl_o),
   .clk_o_i (1'b0)
);

bind nco_accum nco_properties #(.SYNC_SIDE(1'b0)) u_accum_props (
   .clk_i   (in_clk_i),
   .rst_i   (in_rst_i),
   .w_en_i  (1'b0),
   .w_full_i(1'b0),
   .in_clk_i(in_clk_i),
   .in_rst_i(in_rst_i),
   .ctrl_i  (ctrl_i),
   .clk_o_i (clk_o)
);

`default_nettype wire

//--- sim/nco_tb.sv
/*
 * nco testbench: replays register commands from a stimulus file and
 * measures clk_o in in_clk_i cycles against the expected totals
 */
`default_nettype none

module nco_tb;

   // longest output period is 256 in_clk_i cycles
   localparam int EDGE_TIMEOUT = 600;
   // levels land two in_clk_i edges after the register, then clk_o follows
   localparam int SETTLE       = 4;

   logic                           clk_i    = 1'b0;
   logic                           in_clk_i = 1'b0;
   logic                           rst_i;
   logic                           csr_valid_i;
   logic                           csr_we_i;
   logic [nco_pkg::CSR_ADDR_W-1:0] csr_addr_i;
   logic [nco_pkg::CSR_DATA_W-1:0] csr_wdata_i;
   logic [nco_pkg::CSR_DATA_W-1:0] csr_rdata_o;
   logic                           clk_o;

   int errors   = 0;
   int timeouts = 0;

   // clk_o history, sampled on the falling in_clk_i edge
   int   in_cycles  = 0;
   int   rises      = 0;
   int   rise_at    = 0;
   int   fall_at    = 0;
   logic clk_o_seen = 1'b0;

   nco_top u_dut (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .in_clk_i   (in_clk_i),
      .csr_valid_i(csr_valid_i),
      .csr_we_i   (csr_we_i),
      .csr_addr_i (csr_addr_i),
      .csr_wdata_i(csr_wdata_i),
      .csr_rdata_o(csr_rdata_o),
      .clk_o      (clk_o)
   );

   always #10 clk_i = ~clk_i;
   always #7 in_clk_i = ~in_clk_i;

   always @(negedge in_clk_i) begin
      in_cycles = in_cycles + 1;
      if (clk_o === 1'b1 && clk_o_seen === 1'b0) begin
         rises   = rises + 1;
         rise_at = in_cycles;
      end
      if (clk_o === 1'b0 && clk_o_seen === 1'b1) begin
         fall_at = in_cycles;
      end
      clk_o_seen = clk_o;
   end

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors = errors + 1;
         $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      @(posedge clk_i);
      #2;
      csr_valid_i = 1'b1;
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(posedge clk_i);
      #2;
      csr_valid_i = 1'b0;
      csr_we_i    = 1'b0;
   endtask

   // read data is registered on the edge that sees the request
   task automatic read_check(input logic [1:0] addr, input logic [15:0] exp);
      @(posedge clk_i);
      #2;
      csr_valid_i = 1'b1;
      csr_we_i    = 1'b0;
      csr_addr_i  = addr;
      @(posedge clk_i);
      #2;
      csr_valid_i = 1'b0;
      check_value($sformatf("readback of register %0d", addr), 32'(csr_rdata_o), 32'(exp));
   endtask

   task automatic wait_rise(output bit ok);
      int start;
      int n;
      start = rises;
      n     = 0;
      ok    = 1'b0;
      while (!ok && n < EDGE_TIMEOUT) begin
         @(posedge in_clk_i);
         n  = n + 1;
         ok = (rises != start);
      end
      if (!ok) begin
         timeouts = timeouts + 1;
         $display("timeout at %0t: clk_o had no rising edge in %0d in_clk_i cycles",
                  $time, EDGE_TIMEOUT);
      end
   endtask

   task automatic hold_low(input int cycles);
      int start;
      int n;
      for (n = 0; n < SETTLE; n++) begin
         @(posedge in_clk_i);
      end
      start = rises;
      for (n = 0; n < cycles; n++) begin
         @(posedge in_clk_i);
      end
      check_value("clk_o rising edges while stopped", 32'(rises - start), 32'd0);
      check_value("clk_o level while stopped", 32'(clk_o_seen), 32'd0);
   endtask

   // first edge after a start is partial, so timing begins at the second
   task automatic measure(input int periods, input int total);
      bit ok;
      int first;
      int prev;
      int k;
      wait_rise(ok);
      if (ok) begin
         wait_rise(ok);
      end
      first = rise_at;
      prev  = rise_at;
      k     = 0;
      while (ok && k < periods) begin
         wait_rise(ok);
         // integer period: every interval equal, high for half of it
         if (ok && total % periods == 0) begin
            check_value("period length", 32'(rise_at - prev), 32'(total / periods));
            check_value("high time", 32'(fall_at - prev), 32'(total / periods / 2));
         end
         prev = rise_at;
         k    = k + 1;
      end
      if (ok) begin
         check_value($sformatf("cycles over %0d periods", periods), 32'(rise_at - first),
                     32'(total));
      end
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      string       cmd;
      logic [31:0] a;
      logic [31:0] b;
      rst_i       = 1'b1;
      csr_valid_i = 1'b0;
      csr_we_i    = 1'b0;
      csr_addr_i  = '0;
      csr_wdata_i = '0;
      for (n = 0; n < 10; n++) begin
         @(posedge clk_i);
      end
      #2;
      rst_i = 1'b0;
      fd = $fopen("sim/nco_stimulus.txt", "r");
      if (fd == 0) begin
         errors = errors + 1;
         $display("could not open the stimulus file sim/nco_stimulus.txt");
      end else begin
         while (!$feof(fd) && timeouts == 0) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
               a = '0;
               b = '0;
               n = $sscanf(line, "%s %h %h", cmd, a, b);
               if (cmd == "write") begin
                  write_reg(a[1:0], b[15:0]);
               end else if (cmd == "read") begin
                  read_check(a[1:0], b[15:0]);
               end else if (cmd == "idle") begin
                  hold_low(int'(a));
               end else if (cmd == "measure") begin
                  measure(int'(a), int'(b));
               end else begin
                  errors = errors + 1;
                  $display("unknown command in the stimulus file: %s", cmd);
               end
            end
         end
         $fclose(fd);
      end
      $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/nco_stimulus.txt
# command and hex arguments: write addr data, read addr expected,
# idle in_clk_cycles, measure periods expected_in_clk_total
idle 32
read 0 0
read 1 0
read 2 0400
write 2 beef
read 2 beef
write 0 1
read 0 1
write 0 0
write 2 0600
idle 28
write 1 1
read 1 1
measure 8 30
write 1 0
write 2 0a40
idle 28
write 1 1
measure 100 a40
write 0 1
idle 28
write 2 0700
read 2 0700
idle 28
write 0 0
measure 100 a40

//--- files.f
src/nco_pkg.sv
src/nco_csrs.sv
src/nco_period_fifo.sv
src/nco_sync.sv
src/nco_accum.sv
src/nco_top.sv
sim/nco_properties.sv
sim/nco_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
TOP       := nco_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
